// ==== build.f ====
verilog/mrd_pkg.sv
verilog/mrd_rd_ctrl.sv
verilog/mrd_bfly_addr_gen.sv
verilog/mrd_bank_map.sv
verilog/mrd_bank_ram.sv
verilog/mrd_lane_align.sv
verilog/mrd_rd_top.sv
verif/mrd_rd_tb.sv

// ==== verif/mrd_rd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_rd_tb;
	import mrd_pkg::*;

	localparam int n_frames = 8;
	localparam int n_lens = 12;

	logic clk;
	logic rst_n;
	logic wr_en;
	logic [w_addr-1:0] wr_addr;
	sample_t wr_data;
	logic start;
	logic [2:0] radix;
	logic [w_addr-1:0] dft_len;
	rd_lanes_t out_lanes;
	logic busy;
	logic rd_end;

	integer seed = 94749;
	integer cycles = 0;
	integer limit = 0;
	string test_name = "reset";

	// reference copy of the loaded frame
	sample_t model_mem [0:4094];
	// lengths built from 2, 3 and 5 only
	int len_table [n_lens] = '{8, 12, 15, 25, 27, 45, 50, 64, 90, 100, 243, 4050};
	int frame_len [n_frames];
	int rad_a [n_frames];
	int rad_b [n_frames];

	// running stage state read by the monitor
	integer cur_radix = 0;
	integer cur_m = 0;
	integer exp_j = 0;
	integer n_end = 0;
	logic prev_valid = 1'b0;
	logic prev_busy = 1'b0;

	mrd_rd_top i_dut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.start     (start),
		.radix     (radix),
		.dft_len   (dft_len),
		.out_lanes (out_lanes),
		.busy      (busy),
		.rd_end    (rd_end)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_lanes(input string what, input rd_lanes_t exp, input rd_lanes_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string what, input integer exp, input integer act);
		if (act !== exp)
		begin
			$display("[FAIL] %s %s: expected %0d actual %0d", test_name, what, exp, act);
			stop_run();
		end
	endtask

	// cycle limit set up by choose_frames
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: stage did not finish within %0d cycles", limit);
			stop_run();
		end
	end

	// ------------------------------------------------------------
	// output monitor sampled mid cycle
	// ------------------------------------------------------------
	always @(negedge clk)
	begin : monitor
		rd_lanes_t want;
		if (out_lanes.valid)
		begin
			if (exp_j >= cur_m)
				check_count("extra valid output", cur_m, exp_j + 1);
			want = '0;
			want.valid = 1'b1;
			want.factor = 3'(cur_radix);
			// lane k of butterfly j sits at j + k*M
			for (int k = 0; k < cur_radix; k++)
				want.d[k] = model_mem[exp_j + k * cur_m];
			check_lanes($sformatf("butterfly %0d", exp_j), want, out_lanes);
			exp_j = exp_j + 1;
		end
		else
			check_count("factor without valid", 0, out_lanes.factor);
		if (rd_end)
		begin
			check_count("rd_end pulses", 1, n_end + 1);
			check_count("valid on cycle before rd_end", 1, prev_valid);
			check_count("busy on cycle before rd_end", 1, prev_busy);
			check_count("outputs at rd_end", cur_m, exp_j);
			check_count("busy at rd_end", 0, busy);
			n_end = n_end + 1;
		end
		prev_valid = out_lanes.valid;
		prev_busy = busy;
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	task automatic pick_radix(input int len, input int avoid, output int r);
		int cand;
		r = 0;
		for (int t = 0; t < 32 && r == 0; t++)
		begin
			cand = 2 + ($unsigned($random(seed)) % 4);
			if (len % cand == 0 && cand != avoid)
				r = cand;
		end
		// 25, 27, 243 only take one radix
		for (int c = 2; c <= 5 && r == 0; c++)
			if (len % c == 0)
				r = c;
	endtask

	task automatic choose_frames();
		int pick;
		limit = 0;
		for (int f = 0; f < n_frames; f++)
		begin
			// first two frames cover every radix
			if (f == 0)
			begin
				frame_len[f] = 60;
				rad_a[f] = 2;
				rad_b[f] = 3;
			end
			else if (f == 1)
			begin
				frame_len[f] = 120;
				rad_a[f] = 4;
				rad_b[f] = 5;
			end
			else
			begin
				pick = $unsigned($random(seed)) % n_lens;
				frame_len[f] = len_table[pick];
				pick_radix(frame_len[f], 0, rad_a[f]);
				pick_radix(frame_len[f], rad_a[f], rad_b[f]);
			end
			// each of the two stages counts load, length and slack
			limit = limit + 2 * (2 * frame_len[f] + 64);
		end
	endtask

	task automatic load_frame(input int len);
		sample_t s;
		for (int a = 0; a < len; a++)
		begin
			s.re = w_data'($random(seed));
			s.im = w_data'($random(seed));
			model_mem[a] = s;
			@(posedge clk);
			#1;
			wr_en = 1'b1;
			wr_addr = w_addr'(a);
			wr_data = s;
		end
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic run_stage(input int f, input int r, input int len, input bit poke);
		test_name = $sformatf("frame%0d_len%0d_radix%0d", f, len, r);
		cur_radix = r;
		cur_m = len / r;
		exp_j = 0;
		n_end = 0;
		@(posedge clk);
		#1;
		start = 1'b1;
		radix = 3'(r);
		dft_len = w_addr'(len);
		@(posedge clk);
		#1;
		start = 1'b0;
		// stage must run on its latched copy
		radix = 3'd7;
		dft_len = '1;
		check_count("busy after start", 1, busy);
		if (poke)
		begin
			// second start while busy with another radix
			@(posedge clk);
			#1;
			start = 1'b1;
			radix = (r == 5) ? 3'd2 : 3'(r + 1);
			dft_len = w_addr'(60);
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		while (n_end == 0)
			@(posedge clk);
		repeat (4)
			@(negedge clk);
		check_count("busy after stage", 0, busy);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		start = 1'b0;
		radix = 3'd0;
		dft_len = '0;
		choose_frames();

		repeat (16)
		begin
			@(negedge clk);
			check_lanes("out_lanes in reset", '0, out_lanes);
			check_count("busy in reset", 0, busy);
			check_count("rd_end in reset", 0, rd_end);
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_lanes("out_lanes after reset", '0, out_lanes);
		check_count("busy after reset", 0, busy);
		check_count("rd_end after reset", 0, rd_end);

		// same frame read twice so memory must survive the first pass
		for (int f = 0; f < n_frames; f++)
		begin
			load_frame(frame_len[f]);
			run_stage(f, rad_a[f], frame_len[f], 1'b0);
			run_stage(f, rad_b[f], frame_len[f], 1'b1);
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/mrd_bank_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_map
(
	input  wire clk,
	input  wire rst_n,
	input  mrd_pkg::lane_addr_t lane_addr,
	input  wire [2:0] radix_q,
	output mrd_pkg::bank_req_t bank_req,
	output mrd_pkg::lane_map_t lane_map
);
	import mrd_pkg::*;

	logic [n_lanes-1:0][2:0] lane_bank;
	logic [n_lanes-1:0][w_row-1:0] lane_row;
	bank_req_t req_d;

	// ------------------------------------------------------------
	// per lane bank and row
	// ------------------------------------------------------------
	always_comb
	begin
		for (int k = 0; k < n_lanes; k++)
		begin
			lane_row[k] = addr_row(lane_addr.addr[k]);
			// lanes past the radix never hit a bank
			if (k < radix_q)
				lane_bank[k] = addr_bank(lane_addr.addr[k]);
			else
				lane_bank[k] = 3'(bank_none);
		end
	end

	// ------------------------------------------------------------
	// per bank request
	// ------------------------------------------------------------
	always_comb
	begin
		req_d = '0;
		for (int b = 0; b < n_banks; b++)
		begin
			// scan high to low so lane 0 wins
			// no two live lanes share a bank when len is not a multiple of 7
			for (int k = n_lanes - 1; k >= 0; k--)
			begin
				if (lane_bank[k] == 3'(b))
				begin
					req_d.rden[b] = lane_addr.active;
					req_d.row[b] = lane_row[k];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		bank_req.row <= req_d.row;
		// return path needs each lane's bank
		lane_map.bank <= lane_bank;
		if (!rst_n)
		begin
			bank_req.rden <= '0;
			lane_map.live <= 1'b0;
		end
		else
		begin
			bank_req.rden <= req_d.rden;
			lane_map.live <= lane_addr.active;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mrd_bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_ram
(
	input  wire clk,
	input  wire rst_n,
	input  wire wr_en,
	input  wire [mrd_pkg::w_addr-1:0] wr_addr,
	input  mrd_pkg::sample_t wr_data,
	input  mrd_pkg::bank_req_t bank_req,
	output mrd_pkg::sample_t [mrd_pkg::n_banks-1:0] bank_dout
);
	import mrd_pkg::*;

	// load target, same mapping as the read side
	logic [2:0] wr_bank;
	logic [w_row-1:0] wr_row;

	assign wr_bank = addr_bank(wr_addr);
	assign wr_row = addr_row(wr_addr);

	// ------------------------------------------------------------
	// seven single port banks
	// ------------------------------------------------------------
	for (genvar b = 0; b < n_banks; b++)
	begin : g_bank
		sample_t mem [0:2**w_row-1];
		sample_t dout_q;
		logic wr_hit;

		// single port, a read on this bank blocks the load
		assign wr_hit = wr_en && (wr_bank == 3'(b)) && !bank_req.rden[b];

		always_ff @(posedge clk)
		begin
			if (wr_hit)
				mem[wr_row] <= wr_data;
		end

		// one cycle read latency
		always_ff @(posedge clk)
		begin
			if (!rst_n)
				dout_q <= '0;
			else if (bank_req.rden[b])
				dout_q <= mem[bank_req.row[b]];
		end

		assign bank_dout[b] = dout_q;
	end

endmodule

`default_nettype wire

// ==== verilog/mrd_bfly_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_bfly_addr_gen
(
	input  wire clk,
	input  wire rst_n,
	input  wire [mrd_pkg::w_addr-1:0] bfly_idx,
	input  wire [mrd_pkg::w_addr-1:0] stride,
	input  wire [2:0] radix_q,
	input  wire bfly_live,
	output mrd_pkg::lane_addr_t lane_addr
);
	import mrd_pkg::*;

	// lane k sits at j + k*M
	logic [n_lanes-1:0][w_addr-1:0] sum;

	// adder chain, one stride per lane
	always_comb
	begin
		sum[0] = bfly_idx;
		for (int k = 1; k < n_lanes; k++)
			sum[k] = sum[k-1] + stride;
	end

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		// unused lanes parked at 0
		for (int k = 0; k < n_lanes; k++)
			lane_addr.addr[k] <= (k < radix_q) ? sum[k] : '0;

		if (!rst_n)
			lane_addr.active <= 1'b0;
		else
			lane_addr.active <= bfly_live;
	end

endmodule

`default_nettype wire

// ==== verilog/mrd_lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_lane_align
(
	input  wire clk,
	input  wire rst_n,
	input  mrd_pkg::lane_map_t lane_map,
	input  wire [2:0] radix_q,
	input  mrd_pkg::sample_t [mrd_pkg::n_banks-1:0] bank_dout,
	output mrd_pkg::rd_lanes_t out_lanes
);
	import mrd_pkg::*;

	// map delayed one cycle, lines up with ram data
	lane_map_t map_q;

	always_ff @(posedge clk)
	begin
		map_q.bank <= lane_map.bank;
		if (!rst_n)
			map_q.live <= 1'b0;
		else
			map_q.live <= lane_map.live;
	end

	// ------------------------------------------------------------
	// bank -> lane steering
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_lanes <= '0;
		else
		begin
			out_lanes.valid <= map_q.live;
			out_lanes.factor <= map_q.live ? radix_q : 3'd0;
			for (int k = 0; k < n_lanes; k++)
			begin
				// unused lane reads as zero
				if (map_q.bank[k] == 3'(bank_none))
					out_lanes.d[k] <= '0;
				else
					out_lanes.d[k] <= bank_dout[map_q.bank[k]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mrd_pkg.sv ====
`default_nettype none

package mrd_pkg;

	// ------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------
	localparam int n_banks = 7;
	localparam int n_lanes = 5;
	localparam int w_addr = 12;
	localparam int w_row = 10;
	localparam int w_data = 18;
	// idle cycles after stride is known, before first read
	localparam int wait_before_start = 2;
	// lane not used by this radix
	localparam int bank_none = 7;

	typedef enum logic [2:0]
	{
		st_idle,
		st_div,
		st_wait,
		st_rd,
		st_drain
	} rd_state_e;

	// ------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------
	typedef struct packed
	{
		logic [w_data-1:0] re;
		logic [w_data-1:0] im;
	} sample_t;

	typedef struct packed
	{
		logic [n_lanes-1:0][w_addr-1:0] addr;
		logic active;
	} lane_addr_t;

	typedef struct packed
	{
		logic [n_banks-1:0] rden;
		logic [n_banks-1:0][w_row-1:0] row;
	} bank_req_t;

	typedef struct packed
	{
		logic [n_lanes-1:0][2:0] bank;
		logic live;
	} lane_map_t;

	typedef struct packed
	{
		logic valid;
		logic [2:0] factor;
		sample_t [n_lanes-1:0] d;
	} rd_lanes_t;

	// logical address -> bank, addr mod 7
	function automatic logic [2:0] addr_bank(input logic [w_addr-1:0] addr);
		addr_bank = 3'(addr % n_banks);
	endfunction

	// logical address -> row inside bank, addr div 7
	function automatic logic [w_row-1:0] addr_row(input logic [w_addr-1:0] addr);
		addr_row = w_row'(addr / n_banks);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/mrd_rd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_rd_ctrl
(
	input  wire clk,
	input  wire rst_n,
	input  wire start,
	input  wire [2:0] radix,
	input  wire [mrd_pkg::w_addr-1:0] dft_len,
	output logic [2:0] radix_q,
	output logic [mrd_pkg::w_addr-1:0] bfly_idx,
	output logic [mrd_pkg::w_addr-1:0] stride,
	output logic bfly_live,
	output logic busy,
	output logic rd_end
);
	import mrd_pkg::*;

	rd_state_e state;
	// remainder of the running division
	logic [w_addr-1:0] rem;
	// shared by wait and drain phases
	logic [2:0] cnt;

	// ------------------------------------------------------------
	// stage fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			radix_q <= 3'd0;
			rem <= '0;
			stride <= '0;
			bfly_idx <= '0;
			cnt <= 3'd0;
			rd_end <= 1'b0;
		end
		else
		begin
			rd_end <= 1'b0;
			case (state)
				st_idle:
				begin
					// start only taken here, ignored while busy
					if (start)
					begin
						radix_q <= radix;
						rem <= dft_len;
						stride <= '0;
						state <= st_div;
					end
				end
				st_div:
				begin
					// one subtraction per cycle, quotient builds up in stride
					if (radix_q != 3'd0 && rem >= w_addr'(radix_q))
					begin
						rem <= rem - w_addr'(radix_q);
						stride <= stride + 1'b1;
					end
					else
					begin
						cnt <= 3'd0;
						state <= st_wait;
					end
				end
				st_wait:
				begin
					bfly_idx <= '0;
					if (cnt == 3'(wait_before_start - 1))
					begin
						cnt <= 3'd0;
						// empty stage skips straight to drain
						state <= (stride != '0) ? st_rd : st_drain;
					end
					else
						cnt <= cnt + 3'd1;
				end
				st_rd:
				begin
					if (bfly_idx == stride - 1'b1)
					begin
						cnt <= 3'd0;
						state <= st_drain;
					end
					else
						bfly_idx <= bfly_idx + 1'b1;
				end
				st_drain:
				begin
					// four cycles for the pipe to empty
					if (cnt == 3'd3)
					begin
						rd_end <= 1'b1;
						state <= st_idle;
					end
					else
						cnt <= cnt + 3'd1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	assign bfly_live = (state == st_rd);
	assign busy = (state != st_idle);

endmodule

`default_nettype wire

// ==== verilog/mrd_rd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mrd_rd_top
(
	input  wire clk,
	input  wire rst_n,
	// load port, only while idle
	input  wire wr_en,
	input  wire [mrd_pkg::w_addr-1:0] wr_addr,
	input  mrd_pkg::sample_t wr_data,
	// stage control
	input  wire start,
	input  wire [2:0] radix,
	input  wire [mrd_pkg::w_addr-1:0] dft_len,
	output mrd_pkg::rd_lanes_t out_lanes,
	output logic busy,
	output logic rd_end
);
	import mrd_pkg::*;

	logic [2:0] radix_q;
	logic [w_addr-1:0] bfly_idx;
	logic [w_addr-1:0] stride;
	logic bfly_live;
	lane_addr_t lane_addr;
	bank_req_t bank_req;
	lane_map_t lane_map;
	sample_t [n_banks-1:0] bank_dout;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	mrd_rd_ctrl i_ctrl
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.radix     (radix),
		.dft_len   (dft_len),
		.radix_q   (radix_q),
		.bfly_idx  (bfly_idx),
		.stride    (stride),
		.bfly_live (bfly_live),
		.busy      (busy),
		.rd_end    (rd_end)
	);

	// ------------------------------------------------------------
	// datapath, one register per block
	// ------------------------------------------------------------
	mrd_bfly_addr_gen i_addr_gen
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.bfly_idx  (bfly_idx),
		.stride    (stride),
		.radix_q   (radix_q),
		.bfly_live (bfly_live),
		.lane_addr (lane_addr)
	);

	mrd_bank_map i_bank_map
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.lane_addr (lane_addr),
		.radix_q   (radix_q),
		.bank_req  (bank_req),
		.lane_map  (lane_map)
	);

	mrd_bank_ram i_bank_ram
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.bank_req  (bank_req),
		.bank_dout (bank_dout)
	);

	mrd_lane_align i_lane_align
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.lane_map  (lane_map),
		.radix_q   (radix_q),
		.bank_dout (bank_dout),
		.out_lanes (out_lanes)
	);

endmodule

`default_nettype wire
